// ==== tb.f ====
+incdir+dv
common/rv_pkg.sv
design/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
design/execute_stage.sv
design/rv_core.sv
dv/clk_gen.sv
dv/tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	-f tb.f --top-module tb_rv_core -Mdir obj_dir

out="$(./obj_dir/Vtb_rv_core)"
echo "$out"

if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1

// ==== dv/rv_model.svh ====
// rv_model
// Reference model for the rv_core subset: OP, OP-IMM, LUI, AUIPC.
// Executes one instruction word against a model register file and
// reports whether it retires, its destination and its result
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// Architectural registers as seen by the program
logic [31:0] model_regs [32];

// sp starts at the stack top, all else zero
task automatic model_reset();
	for (int i = 0; i < 32; i++) begin
		model_regs[i] = (i == 2) ? 32'h7fff_efe4 : 32'h0;
	end
endtask

// Integer operation by funct3, alt picks sub / arithmetic shift
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
	input logic [31:0] a, input logic [31:0] b);
	logic [31:0] r;
	case (f3)
		3'b000: r = alt ? (a - b) : (a + b);
		3'b001: r = a << b[4:0];
		3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'b011: r = (a < b) ? 32'd1 : 32'd0;
		3'b100: r = a ^ b;
		// Sign fill for sra
		3'b101: r = alt ? $unsigned($signed(a) >>> b[4:0]) : (a >> b[4:0]);
		3'b110: r = a | b;
		default: r = a & b;
	endcase
	return r;
endfunction

// One instruction, in program order
task automatic model_exec(input logic [31:0] pc, input logic [31:0] instr,
	output logic retires, output logic [4:0] rd, output logic [31:0] data);
	logic [2:0]  f3;
	logic [31:0] a;
	logic [31:0] imm_i;
	logic [31:0] imm_u;
	f3      = instr[14:12];
	rd      = instr[11:7];
	a       = model_regs[instr[19:15]];
	imm_i   = {{20{instr[31]}}, instr[31:20]};
	imm_u   = {instr[31:12], 12'h000};
	retires = 1'b1;
	data    = 32'h0;
	case (instr[6:0])
		7'b0110011: data = alu_ref(f3, instr[30], a, model_regs[instr[24:20]]);
		// addi has no sub form, only srai uses bit 30
		7'b0010011: data = alu_ref(f3, (f3 == 3'b101) && instr[30], a, imm_i);
		7'b0110111: data = imm_u;
		7'b0010111: data = pc + imm_u;
		// Anything else is dropped
		default: retires = 1'b0;
	endcase
	if (retires && (rd != 5'd0)) begin
		model_regs[rd] = data;
	end
endtask

`endif

// ==== dv/tb_rv_core.sv ====
// tb_rv_core
// Testbench for rv_core.
// Random program in a Wishbone memory with random wait states,
// each retire record checked against the reference model
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

	// Expected retire record and the test it belongs to
	typedef struct packed {
		retire_t    rec;
		logic [2:0] test;
	} exp_t;

	logic    clk;
	logic    rst_n;
	wb_m2s_t wb_o;
	wb_s2m_t wb_i;
	logic    retire_valid;
	retire_t retire;

	// Wishbone slave state
	logic        ack_r = 1'b0;
	logic [31:0] ack_dat = 32'h0;
	logic [1:0]  wait_left = 2'd0;

	// Program words with their test tags
	logic [31:0] prog [$];
	logic [2:0]  prog_test [$];
	exp_t        exp_q [$];

	int   check_count [1:5];
	int   error_count [1:5];
	int   remaining [1:5];
	logic seen_req = 1'b0;
	logic seen_retire = 1'b0;
	logic all_done = 1'b0;
	logic timed_out = 1'b0;

	`include "rv_model.svh"

	clk_gen u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	rv_core UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.wb_o         (wb_o),
		.wb_i         (wb_i),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	assign wb_i = {ack_dat, ack_r};

	function automatic string test_name(input int t);
		case (t)
			1: return "reset";
			2: return "random ALU program";
			3: return "reset values and x0";
			4: return "dependent chains";
			default: return "LUI, AUIPC and dropped opcodes";
		endcase
	endfunction

	function automatic logic [4:0] rnd_reg(input int lo);
		return 5'($urandom_range(lo, 31));
	endfunction

	// Random OP or OP-IMM word with the given registers
	function automatic logic [31:0] gen_alu(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic imm_form);
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm;
		f3  = 3'($urandom_range(0, 7));
		alt = 1'($urandom_range(0, 1));
		imm = 12'($urandom());
		if (!imm_form) begin
			return {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'd0, rs2, rs1, f3, rd,
				7'b0110011};
		end
		// Shift immediates carry only shamt, plus bit 30 for srai
		if (f3 == 3'b001) begin
			imm = {7'd0, imm[4:0]};
		end else if (f3 == 3'b101) begin
			imm = {1'b0, alt, 5'd0, imm[4:0]};
		end
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	// Word beyond the program reads as addi x0,x0,0
	function automatic logic [31:0] mem_word(input logic [31:0] adr);
		int unsigned idx;
		idx = 32'(adr[31:2]);
		if (idx < prog.size()) begin
			return prog[idx];
		end
		return 32'h0000_0013;
	endfunction

	task automatic add_word(input logic [31:0] w, input logic [2:0] t);
		prog.push_back(w);
		prog_test.push_back(t);
	endtask

	task automatic build_program();
		logic [4:0]  prev;
		logic [4:0]  next;
		logic [31:0] w;
		// addi x5,x2,0 first, reads the sp reset value
		add_word({12'd0, 5'd2, 3'b000, 5'd5, 7'b0010011}, 3'd3);
		for (int i = 0; i < 60; i++) begin
			add_word(gen_alu(rnd_reg(0), rnd_reg(0), rnd_reg(0), 1'($urandom_range(0, 1))),
				3'd2);
		end
		// Each one reads the rd just written
		prev = rnd_reg(1);
		for (int i = 0; i < 20; i++) begin
			next = rnd_reg(1);
			add_word(gen_alu(next, prev, ($urandom_range(0, 1) != 0) ? prev : rnd_reg(0),
				1'($urandom_range(0, 1))), 3'd4);
			prev = next;
		end
		// LUI, AUIPC, stores and branches mixed
		for (int i = 0; i < 24; i++) begin
			w = $urandom();
			case ($urandom_range(0, 3))
				0: w[6:0] = 7'b0110111;
				1: w[6:0] = 7'b0010111;
				2: w[6:0] = 7'b0100011;
				default: w[6:0] = 7'b1100011;
			endcase
			add_word(w, 3'd5);
		end
		for (int i = 0; i < 8; i++) begin
			add_word(gen_alu(5'd0, rnd_reg(0), rnd_reg(0), 1'($urandom_range(0, 1))), 3'd3);
		end
		// or x6,x0,x0 and addi x7,x0,0
		add_word({7'd0, 5'd0, 5'd0, 3'b110, 5'd6, 7'b0110011}, 3'd3);
		add_word({12'd0, 5'd0, 3'b000, 5'd7, 7'b0010011}, 3'd3);
	endtask

	// Expected retires in program order
	task automatic predict();
		exp_t        e;
		logic        ret;
		logic [4:0]  rd;
		logic [31:0] data;
		model_reset();
		for (int i = 0; i < prog.size(); i++) begin
			e.rec.pc = 32'(i * 4);
			e.test   = prog_test[i];
			model_exec(e.rec.pc, prog[i], ret, rd, data);
			e.rec.rd   = rd;
			e.rec.data = data;
			if (ret) begin
				exp_q.push_back(e);
				remaining[int'(e.test)]++;
			end
		end
	endtask

	task automatic check_field(input int t, input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		check_count[t]++;
		assert (got === exp) else begin
			$display("** Error at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
			error_count[t]++;
		end
	endtask

	task automatic report_test(input int t);
		$display("test %0d, %s: %s, %0d checks, %0d errors", t, test_name(t),
			(error_count[t] == 0) ? "ok" : "FAILED", check_count[t], error_count[t]);
	endtask

	function automatic int sum_counts(input logic errors);
		int s;
		s = 0;
		for (int t = 1; t <= 5; t++) begin
			s += errors ? error_count[t] : check_count[t];
		end
		return s;
	endfunction

	// Wishbone memory, 0 to 3 wait states per read
	always @(posedge clk) begin
		if (!rst_n) begin
			ack_r <= 1'b0;
		end else if (ack_r) begin
			ack_r <= 1'b0;
		end else if (wb_o.cyc && wb_o.stb) begin
			if (wait_left == 2'd0) begin
				ack_r     <= 1'b1;
				ack_dat   <= mem_word(wb_o.adr);
				wait_left <= 2'($urandom_range(0, 3));
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

	// Bus and retire monitor
	always @(posedge clk) begin : monitor
		exp_t e;
		int   t;
		int   idx;
		if (!rst_n) begin
			check_field(1, "wb_o.cyc", 32'(wb_o.cyc), 32'd0);
			check_field(1, "wb_o.stb", 32'(wb_o.stb), 32'd0);
			check_field(1, "retire_valid", 32'(retire_valid), 32'd0);
		end else begin
			if (wb_o.cyc && wb_o.stb && !seen_req) begin
				seen_req = 1'b1;
				check_field(1, "wb_o.adr", wb_o.adr, 32'd0);
			end
			// Read only bus, we low in every request cycle
			idx = int'(wb_o.adr[31:2]);
			if (wb_o.cyc && wb_o.stb && (idx < prog.size())) begin
				check_field(int'(prog_test[idx]), "wb_o.we", 32'(wb_o.we), 32'd0);
			end
			if (retire_valid && (exp_q.size() > 0)) begin
				e = exp_q.pop_front();
				t = int'(e.test);
				if (!seen_retire) begin
					seen_retire = 1'b1;
					check_field(1, "retire.pc", retire.pc, 32'd0);
					report_test(1);
				end
				check_field(t, "retire.pc", retire.pc, e.rec.pc);
				check_field(t, "retire.rd", 32'(retire.rd), 32'(e.rec.rd));
				check_field(t, "retire.data", retire.data, e.rec.data);
				remaining[t]--;
				if (remaining[t] == 0) begin
					report_test(t);
				end
				if (exp_q.size() == 0) begin
					all_done = 1'b1;
				end
			end
		end
	end

	initial begin
		int limit;
		void'($urandom(82550));
		build_program();
		predict();
		// 8 cycles per word, reset, margin
		limit = prog.size() * 8 + 10 + 100;
		fork
			wait (all_done);
			begin
				repeat (limit) @(posedge clk);
				timed_out = 1'b1;
			end
		join_any
		if (timed_out) begin
			$display("watchdog: program did not retire within %0d cycles", limit);
		end
		$display("closing: %0d checks, %0d errors", sum_counts(1'b0), sum_counts(1'b1));
		if (!timed_out && (sum_counts(1'b1) == 0)) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== dv/clk_gen.sv ====
// clk_gen
// Testbench clock and reset.
// 20 ns clock, rst_n held low for the first 10 rising edges
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst_n
);

	// Half period 10 ns
	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// Release on a rising edge like any other driven input
	initial begin
		rst_n = 1'b0;
		repeat (10) begin
			@(posedge clk);
		end
		rst_n <= 1'b1;
	end

endmodule

// ==== design/rv_core.sv ====
// rv_core
// In-order three stage RV32I subset pipeline.
// Fetch over Wishbone classic, decode with register file, execute with
// write-back, plus a retire port reporting every completed instruction
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	output wb_m2s_t wb_o,
	input  wb_s2m_t wb_i,
	output logic    retire_valid,
	output retire_t retire
);

	// Fetch to decode
	logic fd_valid;
	fd_t  fd;
	logic fd_ready;

	// Decode to execute, execute never stalls
	logic de_valid;
	de_t  de;

	// Write-back into the register file
	logic              wb_en;
	logic [REG_AW-1:0] wb_rd;
	logic [XLEN-1:0]   wb_data;

	fetch_stage u_fetch_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_o     (wb_o),
		.wb_i     (wb_i),
		.fd_valid (fd_valid),
		.fd       (fd),
		.fd_ready (fd_ready)
	);

	decode_stage u_decode_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.fd_valid (fd_valid),
		.fd       (fd),
		.fd_ready (fd_ready),
		.wb_en    (wb_en),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data),
		.de_valid (de_valid),
		.de       (de)
	);

	execute_stage u_execute_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.de_valid     (de_valid),
		.de           (de),
		.wb_en        (wb_en),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

endmodule

// ==== design/execute_stage.sv ====
// execute_stage
// RV32I integer ALU and the execute/retire register.
// The registered result feeds the register file write port and the
// retire port in the same cycle
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              de_valid,
	input  de_t               de,
	output logic              wb_en,
	output logic [REG_AW-1:0] wb_rd,
	output logic [XLEN-1:0]   wb_data,
	output logic              retire_valid,
	output retire_t           retire
);

	// Shift amount, low five bits only
	logic [4:0]      shamt;
	logic [XLEN-1:0] result;
	logic            lt_s;
	logic            lt_u;

	assign shamt = de.b[4:0];
	assign lt_s  = $signed(de.a) < $signed(de.b);
	assign lt_u  = de.a < de.b;

	// ALU
	always_comb begin
		case (de.alu_op)
			ALU_ADD: begin
				result = de.a + de.b;
			end
			ALU_SUB: begin
				result = de.a - de.b;
			end
			ALU_SLL: begin
				result = de.a << shamt;
			end
			ALU_SLT: begin
				result = {{(XLEN-1){1'b0}}, lt_s};
			end
			ALU_SLTU: begin
				result = {{(XLEN-1){1'b0}}, lt_u};
			end
			ALU_XOR: begin
				result = de.a ^ de.b;
			end
			ALU_SRL: begin
				result = de.a >> shamt;
			end
			ALU_SRA: begin
				// Keep the sign bit
				result = $unsigned($signed(de.a) >>> shamt);
			end
			ALU_OR: begin
				result = de.a | de.b;
			end
			ALU_AND: begin
				result = de.a & de.b;
			end
			default: begin
				// LUI
				result = de.b;
			end
		endcase
	end

	// One cycle pulse per instruction
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= de_valid;
		end
	end

	// Retire record
	always_ff @(posedge clk) begin
		if (de_valid) begin
			retire.pc   <= de.pc;
			retire.rd   <= de.rd;
			retire.data <= result;
		end
	end

	// Write-back, same content as retire
	// x0 filtered in the register file
	assign wb_en   = retire_valid;
	assign wb_rd   = retire.rd;
	assign wb_data = retire.data;

endmodule

// ==== decode/decode_stage.sv ====
// decode_stage
// Instruction decode for OP, OP-IMM, LUI and AUIPC.
// Reads operands from the register file, builds the I/U immediates,
// picks the ALU operation and operands, stalls on a pending write to
// a source register and drops any other opcode
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              fd_valid,
	input  fd_t               fd,
	output logic              fd_ready,
	input  logic              wb_en,
	input  logic [REG_AW-1:0] wb_rd,
	input  logic [XLEN-1:0]   wb_data,
	output logic              de_valid,
	output de_t               de
);

	// Instruction fields
	logic [6:0]        opcode;
	logic [REG_AW-1:0] rd;
	logic [2:0]        funct3;
	logic [REG_AW-1:0] rs1;
	logic [REG_AW-1:0] rs2;
	logic [6:0]        funct7;

	// Immediates
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_u;

	// Operand values
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;

	// Decode results
	logic    is_op;
	logic    is_op_imm;
	logic    is_lui;
	logic    is_auipc;
	logic    supported;
	logic    use_rs1;
	logic    use_rs2;
	alu_op_e alu_op;
	logic    wb_hit;
	logic    stall;
	logic    take;

	assign opcode = fd.instr[6:0];
	assign rd     = fd.instr[11:7];
	assign funct3 = fd.instr[14:12];
	assign rs1    = fd.instr[19:15];
	assign rs2    = fd.instr[24:20];
	assign funct7 = fd.instr[31:25];

	// Sign extended 12 bit, and upper 20 bit
	assign imm_i = {{(XLEN-12){fd.instr[31]}}, fd.instr[31:20]};
	assign imm_u = {fd.instr[31:12], 12'b0};

	assign is_op     = (opcode == OPC_OP);
	assign is_op_imm = (opcode == OPC_OP_IMM);
	assign is_lui    = (opcode == OPC_LUI);
	assign is_auipc  = (opcode == OPC_AUIPC);
	assign supported = is_op || is_op_imm || is_lui || is_auipc;

	// Which sources are really read
	assign use_rs1 = is_op || is_op_imm;
	assign use_rs2 = is_op;

	register_file u_register_file (
		.clk   (clk),
		.rst_n (rst_n),
		.a1    (rs1),
		.a2    (rs2),
		.a3    (wb_rd),
		.we3   (wb_en),
		.wd3   (wb_data),
		.rd1   (rs1_val),
		.rd2   (rs2_val)
	);

	// funct3/funct7 to ALU op
	always_comb begin
		alu_op = ALU_ADD;
		if (is_lui) begin
			alu_op = ALU_PASS_B;
		end else if (is_op || is_op_imm) begin
			case (funct3)
				// sub only for register form, addi has no funct7
				3'b000: alu_op = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
				3'b001: alu_op = ALU_SLL;
				3'b010: alu_op = ALU_SLT;
				3'b011: alu_op = ALU_SLTU;
				3'b100: alu_op = ALU_XOR;
				// Bit 30 selects arithmetic shift in both forms
				3'b101: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
				3'b110: alu_op = ALU_OR;
				default: alu_op = ALU_AND;
			endcase
		end
	end

	// Source matches the execute register's pending write-back.
	// The write lands on the next edge
	assign wb_hit = wb_en && (wb_rd != '0)
		&& ((use_rs1 && (wb_rd == rs1)) || (use_rs2 && (wb_rd == rs2)));
	assign stall  = wb_hit;

	assign fd_ready = !stall;
	assign take     = fd_valid && !stall;

	// Unsupported words are consumed but never go on
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			de_valid <= 1'b0;
		end else begin
			de_valid <= take && supported;
		end
	end

	// Decode/execute payload
	always_ff @(posedge clk) begin
		if (take) begin
			de.pc     <= fd.pc;
			de.alu_op <= alu_op;
			// AUIPC adds to pc, else rs1
			de.a      <= is_auipc ? fd.pc : rs1_val;
			de.b      <= is_op ? rs2_val : ((is_lui || is_auipc) ? imm_u : imm_i);
			de.rd     <= rd;
		end
	end

endmodule

// ==== decode/register_file.sv ====
// register_file
// RV32I integer registers, 32 x 32 bit.
// x2 comes out of reset holding the stack top, the rest hold zero.
// One write port, x0 writes dropped, two combinational read ports
`timescale 1ns/1ps

module register_file import rv_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [REG_AW-1:0] a1,
	input  logic [REG_AW-1:0] a2,
	input  logic [REG_AW-1:0] a3,
	input  logic              we3,
	input  logic [XLEN-1:0]   wd3,
	output logic [XLEN-1:0]   rd1,
	output logic [XLEN-1:0]   rd2
);

	logic [XLEN-1:0] regs [32];

	// Register array with reset values
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				// sp gets the stack top
				if (i == 2) begin
					regs[i] <= SP_RESET;
				end else begin
					regs[i] <= '0;
				end
			end
		end else if (we3 && (a3 != '0)) begin
			// x0 never written, stays zero
			regs[a3] <= wd3;
		end
	end

	// Asynchronous reads
	// A write shows up here right after its edge
	assign rd1 = regs[a1];
	assign rd2 = regs[a2];

endmodule

// ==== design/fetch_stage.sv ====
// fetch_stage
// Instruction fetch over a read-only Wishbone classic bus.
// Walks the address space in order, one word per bus cycle, and keeps
// the fetched word with its pc until decode takes it
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	output wb_m2s_t wb_o,
	input  wb_s2m_t wb_i,
	output logic    fd_valid,
	output fd_t     fd,
	input  logic    fd_ready
);

	// Bus cycle in progress
	logic            req;
	// Address of the next word
	logic [XLEN-1:0] pc;
	// Word returned this cycle
	logic            done;
	// Launch a new bus cycle
	logic            start;

	assign done = req && wb_i.ack;

	// Only from an idle bus, so cyc/stb stay low for a cycle after each ack.
	// Holding reg must be empty or leaving this edge
	assign start = !req && (!fd_valid || fd_ready);

	// Read only, we tied low
	assign wb_o = '{cyc: req, stb: req, we: 1'b0, adr: pc};

	// Request flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req <= 1'b0;
		end else if (done) begin
			req <= 1'b0;
		end else if (start) begin
			req <= 1'b1;
		end
	end

	// Sequential pc, steps on each ack
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (done) begin
			pc <= pc + XLEN'(4);
		end
	end

	// Fetch/decode valid
	// Register is always empty when the ack lands
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fd_valid <= 1'b0;
		end else if (done) begin
			fd_valid <= 1'b1;
		end else if (fd_ready) begin
			fd_valid <= 1'b0;
		end
	end

	// Fetched word and its address
	always_ff @(posedge clk) begin
		if (done) begin
			fd.pc    <= pc;
			fd.instr <= wb_i.dat;
		end
	end

endmodule

// ==== common/rv_pkg.sv ====
// rv_pkg
// Shared definitions for the rv_core integer pipeline:
// widths, reset constants, RV32I major opcodes, ALU operation codes,
// stage payloads, the retire record and the Wishbone classic signal groups
package rv_pkg;

	// Data and address width
	localparam int XLEN   = 32;
	// Register address width, 32 registers
	localparam int REG_AW = 5;

	// Stack top loaded into x2 at reset
	localparam logic [XLEN-1:0] SP_RESET = 32'h7fff_efe4;

	// Supported major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	// ALU operations
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		// LUI result is operand b as is
		ALU_PASS_B = 4'd10
	} alu_op_e;

	// Fetch to decode
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0]     instr;
	} fd_t;

	// Decode to execute, operands already selected
	typedef struct packed {
		logic [XLEN-1:0]   pc;
		alu_op_e           alu_op;
		logic [XLEN-1:0]   a;
		logic [XLEN-1:0]   b;
		logic [REG_AW-1:0] rd;
	} de_t;

	// One record per retired instruction
	typedef struct packed {
		logic [XLEN-1:0]   pc;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0]   data;
	} retire_t;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic            cyc;
		logic            stb;
		logic            we;
		logic [XLEN-1:0] adr;
	} wb_m2s_t;

	// Wishbone classic, slave to master
	typedef struct packed {
		logic [XLEN-1:0] dat;
		logic            ack;
	} wb_s2m_t;

endpackage
